// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_u2_rx_core -f src.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"

// File: source/ddc_channel.sv
module ddc_channel import rx_core_pkg::*; #(
   parameter int CHAN = 0
) (
   input  logic        dsp_clk,
   input  logic        por_rst,
   input  logic        set_stb_i,
   input  set_addr_t   set_addr_i,
   input  set_data_t   set_data_i,
   input  sample_t     fe_i_i,
   input  sample_t     fe_q_i,
   input  vita_time_t  vita_time_i,
   rx_sample_if.source smp,
   output logic        running_o,
   output logic        overrun_o
);

   chan_state_t   state;
   decim_t        decim;
   decim_t        dcnt;        // Samples summed so far in this dump
   sample_count_t total;       // Items requested by the command
   sample_count_t scnt;        // Items produced in this run
   sample_t       acc_i;
   sample_t       acc_q;
   sample_t       sum_i;
   sample_t       sum_q;
   sample_t       hold_i;
   sample_t       hold_q;
   vita_time_t    hold_time;
   logic          hold_last;
   logic          req_r;
   logic          full;        // Holding register has an item not yet acked
   logic          overrun_r;
   logic          cmd_wr;
   logic          decim_wr;
   logic          start;
   logic          stop;
   logic          step;
   logic          dump;
   logic          ack_done;
   logic          load;
   logic          is_last;

   assign cmd_wr   = set_stb_i && (set_addr_i == rx_ctrl_addr(CHAN, RX_CMD_OFS));
   assign decim_wr = set_stb_i && (set_addr_i == rx_ctrl_addr(CHAN, RX_DECIM_OFS));
   assign start    = cmd_wr && set_data_i[CMD_START_BIT] && (set_data_i[15:0] != '0);
   assign stop     = cmd_wr && !set_data_i[CMD_START_BIT];

   assign step     = (state == CH_RUN) && !start && !stop;
   assign dump     = step && (dcnt >= decim_t'(decim - 8'd1));
   assign ack_done = req_r && smp.ack;
   assign load     = dump && (!full || ack_done);   // No room means overrun
   assign is_last  = (sample_count_t'(scnt + 16'd1) == total);

   assign sum_i = acc_i + fe_i_i;
   assign sum_q = acc_q + fe_q_i;

   //////////////////////////////////////////////////
   // Run control and source handshake

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state     <= CH_IDLE;
         decim     <= 8'd1;
         dcnt      <= '0;
         scnt      <= '0;
         total     <= '0;
         req_r     <= 1'b0;
         full      <= 1'b0;
         overrun_r <= 1'b0;
      end else begin
         if (decim_wr) begin
            decim <= (set_data_i[7:0] == '0) ? 8'd1 : set_data_i[7:0];
         end
         if (ack_done) begin
            req_r <= 1'b0;
            full  <= 1'b0;
         end else if (full && !req_r && !smp.ack) begin
            req_r <= 1'b1;   // Sink has finished the previous exchange
         end
         if (start) begin
            state     <= CH_RUN;
            overrun_r <= 1'b0;
            dcnt      <= '0;
            scnt      <= '0;
            total     <= set_data_i[15:0];
         end else if (stop) begin
            state <= CH_IDLE;
         end else if (dump) begin
            dcnt <= '0;
            if (load) begin
               full  <= 1'b1;
               req_r <= !smp.ack;   // Held back while ack is still high
               scnt  <= scnt + 16'd1;
               if (is_last) begin
                  state <= CH_IDLE;
               end
            end else begin
               overrun_r <= 1'b1;
               state     <= CH_IDLE;
            end
         end else if (step) begin
            dcnt <= dcnt + 8'd1;
         end
      end
   end

   // Boxcar sum and the offered item
   always_ff @(posedge dsp_clk) begin
      if (start || dump) begin
         acc_i <= '0;
         acc_q <= '0;
      end else if (step) begin
         acc_i <= sum_i;
         acc_q <= sum_q;
      end
      if (load) begin
         hold_i    <= sum_i;
         hold_q    <= sum_q;
         hold_time <= vita_time_i;   // Stamp of the last sample in the sum
         hold_last <= is_last;
      end
   end

   assign smp.req   = req_r;
   assign smp.i     = hold_i;
   assign smp.q     = hold_q;
   assign smp.vtime = hold_time;
   assign smp.last  = hold_last;
   assign running_o = (state == CH_RUN);
   assign overrun_o = overrun_r;

   // Item on offer may not change until the arbiter acks it
   a_hold_stable: assert property (@(posedge dsp_clk) disable iff (por_rst)
      smp.req && !smp.ack |=> $stable({smp.i, smp.q, smp.vtime, smp.last}));

endmodule

// File: source/led_ctrl.sv
module led_ctrl import rx_core_pkg::*; (
   input  logic                   dsp_clk,
   input  logic                   por_rst,
   input  logic                   set_stb_i,
   input  set_addr_t              set_addr_i,
   input  set_data_t              set_data_i,
   input  logic [NUM_RX_CHAN-1:0] running_i,
   input  logic [NUM_RX_CHAN-1:0] overrun_i,
   output led_t                   leds_o
);

   led_t led_sw;    // Software LED values
   led_t led_src;   // One selects the hardware bit
   led_t led_hw;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         led_sw  <= '0;
         led_src <= LED_SRC_RESET;
      end else if (set_stb_i) begin
         if (set_addr_i == set_addr_t'(SR_LED_SW)) begin
            led_sw <= set_data_i[7:0];
         end
         if (set_addr_i == set_addr_t'(SR_LED_SRC)) begin
            led_src <= set_data_i[7:0];
         end
      end
   end

   // Run on bit 1, overrun on bit 2
   assign led_hw = {5'b0, |overrun_i, |running_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// File: source/rx_core_pkg.sv
package rx_core_pkg;

   typedef logic        [13:0] adc_t;
   typedef logic signed [15:0] sample_t;
   typedef logic        [63:0] vita_time_t;
   typedef logic        [7:0]  set_addr_t;
   typedef logic        [31:0] set_data_t;
   typedef logic        [7:0]  decim_t;
   typedef logic        [15:0] sample_count_t;
   typedef logic        [0:0]  chan_id_t;
   typedef logic        [7:0]  led_t;

   typedef enum logic {CH_IDLE, CH_RUN} chan_state_t;
   typedef enum logic [1:0] {ARB_IDLE, ARB_TAKE, ARB_SEND, ARB_WAIT} arb_state_t;

   localparam int NUM_RX_CHAN = 2;

   //////////////////////////////////////////////////
   // Settings register map

   localparam int   SR_MISC       = 0;
   localparam int   SR_LED_SW     = SR_MISC + 3;
   localparam int   SR_LED_SRC    = SR_MISC + 6;
   localparam led_t LED_SRC_RESET = 8'h1E;       // Status LEDs on hardware

   localparam int SR_TIME64  = 10;
   localparam int SR_TIME_HI = SR_TIME64 + 0;
   localparam int SR_TIME_LO = SR_TIME64 + 1;    // Commits the whole 64 bits

   localparam int SR_RX_FRONT = 24;
   localparam int SR_OFS_A    = SR_RX_FRONT + 0;
   localparam int SR_OFS_B    = SR_RX_FRONT + 1;

   localparam int SR_RX_CTRL0       = 32;
   localparam int SR_RX_CTRL_STRIDE = 48;
   localparam int RX_CMD_OFS        = 0;         // Start bit and count
   localparam int RX_DECIM_OFS      = 1;
   localparam int CMD_START_BIT     = 31;

   // Control register address for one channel
   function automatic set_addr_t rx_ctrl_addr(input int chan, input int ofs);
      return set_addr_t'(SR_RX_CTRL0 + chan * SR_RX_CTRL_STRIDE + ofs);
   endfunction

endpackage

// File: source/rx_frontend.sv
module rx_frontend import rx_core_pkg::*; (
   input  logic      dsp_clk,
   input  logic      por_rst,
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   input  adc_t      adc_a_i,
   input  adc_t      adc_b_i,
   output sample_t   fe_i_o,
   output sample_t   fe_q_o
);

   sample_t ofs_a;   // DC offset on the I path
   sample_t ofs_b;   // DC offset on the Q path
   logic    ofs_a_wr;
   logic    ofs_b_wr;

   assign ofs_a_wr = set_stb_i && (set_addr_i == set_addr_t'(SR_OFS_A));
   assign ofs_b_wr = set_stb_i && (set_addr_i == set_addr_t'(SR_OFS_B));

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         ofs_a <= '0;
         ofs_b <= '0;
      end else begin
         if (ofs_a_wr) begin
            ofs_a <= sample_t'(set_data_i[15:0]);
         end
         if (ofs_b_wr) begin
            ofs_b <= sample_t'(set_data_i[15:0]);
         end
      end
   end

   // ADC word sits in the top 14 bits, result wraps at 16 bits
   always_ff @(posedge dsp_clk) begin
      fe_i_o <= sample_t'({adc_a_i, 2'b00}) - ofs_a;
      fe_q_o <= sample_t'({adc_b_i, 2'b00}) - ofs_b;
   end

endmodule

// File: source/rx_sample_if.sv
interface rx_sample_if import rx_core_pkg::*; ();

   // Four phase handoff of one decimated item
   logic       req;     // Item offered, data stable
   logic       ack;     // Item captured by the sink
   sample_t    i;
   sample_t    q;
   vita_time_t vtime;   // Time of the last sample in the sum
   logic       last;    // Final item of a counted run

   modport source (
      output req,
      output i,
      output q,
      output vtime,
      output last,
      input  ack
   );

   modport sink (
      input  req,
      input  i,
      input  q,
      input  vtime,
      input  last,
      output ack
   );

endinterface

// File: source/sample_arbiter.sv
module sample_arbiter import rx_core_pkg::*; (
   input  logic       dsp_clk,
   input  logic       por_rst,
   rx_sample_if.sink  chan [NUM_RX_CHAN],
   output logic       out_req_o,
   input  logic       out_ack_i,
   output chan_id_t   out_chan_o,
   output sample_t    out_i_o,
   output sample_t    out_q_o,
   output vita_time_t out_time_o,
   output logic       out_last_o
);

   arb_state_t             state;
   chan_id_t               sel;          // Channel served most recently
   chan_id_t               win;
   logic                   take;
   logic [NUM_RX_CHAN-1:0] req_v;
   logic [NUM_RX_CHAN-1:0] ack_r;
   sample_t                cand_i    [NUM_RX_CHAN];
   sample_t                cand_q    [NUM_RX_CHAN];
   vita_time_t             cand_time [NUM_RX_CHAN];
   logic [NUM_RX_CHAN-1:0] cand_last;

   for (genvar g = 0; g < NUM_RX_CHAN; g++) begin : g_port
      assign req_v[g]     = chan[g].req;
      assign chan[g].ack  = ack_r[g];
      assign cand_i[g]    = chan[g].i;
      assign cand_q[g]    = chan[g].q;
      assign cand_time[g] = chan[g].vtime;
      assign cand_last[g] = chan[g].last;
   end

   // Round robin, the channel right after sel has priority
   always_comb begin
      chan_id_t idx;
      win = sel;
      for (int k = NUM_RX_CHAN; k >= 1; k--) begin
         idx = chan_id_t'((int'(sel) + k) % NUM_RX_CHAN);
         if (req_v[idx]) begin
            win = idx;
         end
      end
   end

   assign take = (state == ARB_IDLE) && !out_ack_i && (|req_v);

   //////////////////////////////////////////////////
   // Handshake FSM for both sides

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state     <= ARB_IDLE;
         sel       <= chan_id_t'(NUM_RX_CHAN - 1);   // Channel 0 goes first
         ack_r     <= '0;
         out_req_o <= 1'b0;
      end else begin
         case (state)
            ARB_IDLE: begin
               if (take) begin
                  sel        <= win;
                  ack_r[win] <= 1'b1;
                  out_req_o  <= 1'b1;
                  state      <= ARB_TAKE;
               end
            end
            ARB_TAKE: begin
               if (out_req_o && out_ack_i) begin
                  out_req_o <= 1'b0;
               end
               if (!req_v[sel]) begin
                  ack_r[sel] <= 1'b0;
                  state      <= (out_req_o && !out_ack_i) ? ARB_SEND : ARB_WAIT;
               end
            end
            ARB_SEND: begin
               if (out_ack_i) begin
                  out_req_o <= 1'b0;
                  state     <= ARB_WAIT;
               end
            end
            ARB_WAIT: begin
               if (!out_ack_i) begin
                  state <= ARB_IDLE;
               end
            end
            default: state <= ARB_IDLE;
         endcase
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (take) begin
         out_i_o    <= cand_i[win];
         out_q_o    <= cand_q[win];
         out_time_o <= cand_time[win];
         out_last_o <= cand_last[win];
      end
   end

   assign out_chan_o = sel;   // Fixed from capture to the next take

   a_out_hold: assert property (@(posedge dsp_clk) disable iff (por_rst)
      out_req_o && !out_ack_i |=> out_req_o);

endmodule

// File: source/u2_rx_core.sv
module u2_rx_core import rx_core_pkg::*; (
   input  logic                   dsp_clk,
   input  logic                   por_rst,
   input  logic                   set_stb_i,
   input  set_addr_t              set_addr_i,
   input  set_data_t              set_data_i,
   input  adc_t                   adc_a_i,
   input  adc_t                   adc_b_i,
   output led_t                   leds_o,
   output logic [NUM_RX_CHAN-1:0] overrun_o,
   output logic                   out_req_o,
   input  logic                   out_ack_i,
   output chan_id_t               out_chan_o,
   output sample_t                out_i_o,
   output sample_t                out_q_o,
   output vita_time_t             out_time_o,
   output logic                   out_last_o
);

   vita_time_t             vita_time;
   sample_t                fe_i;
   sample_t                fe_q;
   logic [NUM_RX_CHAN-1:0] running;

   rx_sample_if smp_if [NUM_RX_CHAN] ();   // Channel to arbiter

   vita_timekeeper vita_timekeeper (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .vita_time_o (vita_time)
   );

   rx_frontend rx_frontend (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .adc_a_i    (adc_a_i),
      .adc_b_i    (adc_b_i),
      .fe_i_o     (fe_i),
      .fe_q_o     (fe_q)
   );

   //////////////////////////////////////////////////
   // Receive channels

   for (genvar g = 0; g < NUM_RX_CHAN; g++) begin : g_rx
      ddc_channel #(.CHAN(g)) ddc_channel (
         .dsp_clk     (dsp_clk),
         .por_rst     (por_rst),
         .set_stb_i   (set_stb_i),
         .set_addr_i  (set_addr_i),
         .set_data_i  (set_data_i),
         .fe_i_i      (fe_i),
         .fe_q_i      (fe_q),
         .vita_time_i (vita_time),
         .smp         (smp_if[g]),
         .running_o   (running[g]),
         .overrun_o   (overrun_o[g])
      );
   end

   sample_arbiter sample_arbiter (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .chan       (smp_if),
      .out_req_o  (out_req_o),
      .out_ack_i  (out_ack_i),
      .out_chan_o (out_chan_o),
      .out_i_o    (out_i_o),
      .out_q_o    (out_q_o),
      .out_time_o (out_time_o),
      .out_last_o (out_last_o)
   );

   led_ctrl led_ctrl (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .running_i  (running),
      .overrun_i  (overrun_o),
      .leds_o     (leds_o)
   );

endmodule

// File: source/vita_timekeeper.sv
module vita_timekeeper import rx_core_pkg::*; (
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   output vita_time_t vita_time_o
);

   logic       hi_wr;
   logic       lo_wr;
   set_data_t  time_hi_pend;   // Upper word waits here for the low word
   vita_time_t time_r;

   assign hi_wr = set_stb_i && (set_addr_i == set_addr_t'(SR_TIME_HI));
   assign lo_wr = set_stb_i && (set_addr_i == set_addr_t'(SR_TIME_LO));

   //////////////////////////////////////////////////
   // Sample time counter

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_hi_pend <= '0;
         time_r       <= '0;
      end else begin
         if (hi_wr) begin
            time_hi_pend <= set_data_i;
         end
         // Low word write loads both halves at once
         if (lo_wr) begin
            time_r <= {time_hi_pend, set_data_i};
         end else begin
            time_r <= time_r + 64'd1;   // One tick per sample clock
         end
      end
   end

   assign vita_time_o = time_r;

endmodule

// File: src.f
source/rx_core_pkg.sv
source/rx_sample_if.sv
source/vita_timekeeper.sv
source/rx_frontend.sv
source/ddc_channel.sv
source/sample_arbiter.sv
source/led_ctrl.sv
source/u2_rx_core.sv
testbench/tb_u2_rx_core.sv

// File: testbench/tb_u2_rx_core.sv
module tb_u2_rx_core import rx_core_pkg::*; ;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 8;
   localparam int QUIET_CYCLES = 40;   // Longer than any gap between two items

   // Cycle budget of each test
   localparam int T_LED    = 400;
   localparam int T_SINGLE = 400;
   localparam int T_TIME   = 400;
   localparam int T_DUAL   = 600;
   localparam int T_OVR    = 400;
   localparam int T_BP     = 400;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + T_LED + T_SINGLE + T_TIME + T_DUAL
                                    + T_OVR + T_BP + 400;

   logic                   dsp_clk;
   logic                   por_rst;
   logic                   set_stb_i;
   set_addr_t              set_addr_i;
   set_data_t              set_data_i;
   adc_t                   adc_a_i;
   adc_t                   adc_b_i;
   led_t                   leds_o;
   logic [NUM_RX_CHAN-1:0] overrun_o;
   logic                   out_req_o;
   logic                   out_ack_i = 1'b0;
   chan_id_t               out_chan_o;
   sample_t                out_i_o;
   sample_t                out_q_o;
   vita_time_t             out_time_o;
   logic                   out_last_o;

   int          errors;
   logic        hold_ack;     // Test holds off the output acknowledge

   // Items seen on the output port, in arrival order
   chan_id_t    got_chan [$];
   sample_t     got_i    [$];
   sample_t     got_q    [$];
   vita_time_t  got_time [$];
   logic        got_last [$];

   u2_rx_core dut0 (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .adc_a_i    (adc_a_i),
      .adc_b_i    (adc_b_i),
      .leds_o     (leds_o),
      .overrun_o  (overrun_o),
      .out_req_o  (out_req_o),
      .out_ack_i  (out_ack_i),
      .out_chan_o (out_chan_o),
      .out_i_o    (out_i_o),
      .out_q_o    (out_q_o),
      .out_time_o (out_time_o),
      .out_last_o (out_last_o)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;
   end

   //////////////////////////////////////////////////
   // Output side of the four phase handshake

   always @(negedge dsp_clk) begin
      if (por_rst) begin
         out_ack_i <= 1'b0;
      end else if (out_ack_i) begin
         out_ack_i <= out_req_o;   // Drop once req has fallen
      end else if (out_req_o && !hold_ack) begin
         got_chan.push_back(out_chan_o);
         got_i.push_back(out_i_o);
         got_q.push_back(out_q_o);
         got_time.push_back(out_time_o);
         got_last.push_back(out_last_o);
         out_ack_i <= 1'b1;
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
      $display("Run ended with %0d errors", errors + 1);
      $display("CHECKS FAILED");
      $finish;
   end

   //////////////////////////////////////////////////
   // Helpers

   // ADC word with two zero bits appended, minus the offset
   function automatic sample_t front_value(input adc_t adc, input sample_t ofs);
      logic [15:0] wide;
      wide = {adc, 2'b00};
      return sample_t'(wide - ofs);
   endfunction

   // Sum of d equal samples, wrapped to 16 bits
   function automatic sample_t boxcar_value(input int d, input sample_t fe);
      logic [15:0] acc;
      acc = '0;
      for (int n = 0; n < d; n++) begin
         acc = acc + fe;
      end
      return sample_t'(acc);
   endfunction

   task automatic check_eq(input string name, input logic [63:0] expv,
                           input logic [63:0] actv);
      if (expv !== actv) begin
         $display("FAILED t=%0t %s expected %0h got %0h", $time, name, expv, actv);
         errors++;
      end
   endtask

   task automatic write_reg(input int addr, input logic [31:0] data);
      @(negedge dsp_clk);
      set_stb_i  <= 1'b1;
      set_addr_i <= set_addr_t'(addr);
      set_data_i <= data;
      @(negedge dsp_clk);
      set_stb_i  <= 1'b0;
   endtask

   task automatic start_chan(input int c, input int d, input int count);
      int base;
      base = SR_RX_CTRL0 + c * SR_RX_CTRL_STRIDE;
      write_reg(base + 1, 32'(d));
      write_reg(base, {1'b1, 15'h0, 16'(count)});
   endtask

   // New ADC words and offsets, returns the front-end values
   task automatic random_front(output sample_t fe_i, output sample_t fe_q);
      adc_t    a;
      adc_t    b;
      sample_t oa;
      sample_t ob;
      a  = adc_t'($urandom);
      b  = adc_t'($urandom);
      oa = sample_t'($urandom);
      ob = sample_t'($urandom);
      @(negedge dsp_clk);
      adc_a_i <= a;
      adc_b_i <= b;
      write_reg(SR_OFS_A, {16'h0, oa});
      write_reg(SR_OFS_B, {16'h0, ob});
      fe_i = front_value(a, oa);
      fe_q = front_value(b, ob);
   endtask

   task automatic clear_items();
      got_chan.delete();
      got_i.delete();
      got_q.delete();
      got_time.delete();
      got_last.delete();
   endtask

   task automatic wait_items(input int n, input int budget);
      int cyc;
      cyc = 0;
      while (got_i.size() < n && cyc < budget) begin
         @(negedge dsp_clk);
         cyc++;
      end
      if (got_i.size() < n) begin
         $display("ERROR: only %0d of %0d items arrived in time", got_i.size(), n);
         errors++;
      end
   endtask

   task automatic wait_idle(input int budget);
      int quiet;
      int cyc;
      quiet = 0;
      cyc   = 0;
      while (quiet < QUIET_CYCLES && cyc < budget) begin
         @(negedge dsp_clk);
         cyc++;
         if (!out_req_o && !out_ack_i) begin
            quiet++;
         end else begin
            quiet = 0;
         end
      end
      if (quiet < QUIET_CYCLES) begin
         $display("ERROR: output port never went quiet");
         errors++;
      end
   endtask

   task automatic wait_overrun(input int c, input int budget);
      int cyc;
      cyc = 0;
      while (!overrun_o[c] && cyc < budget) begin
         @(negedge dsp_clk);
         cyc++;
      end
      if (!overrun_o[c]) begin
         $display("ERROR: overrun_o[%0d] never rose", c);
         errors++;
      end
   endtask

   // Values, time steps and last markers of one channel's items
   task automatic check_chan(input int c, input int d, input sample_t ei, input sample_t eq,
                             input int count, input bit full_run, output int n_found);
      vita_time_t prev;
      logic       exp_last;
      n_found = 0;
      prev    = '0;
      for (int k = 0; k < got_i.size(); k++) begin
         if (int'(got_chan[k]) == c) begin
            check_eq("out_i_o", {48'h0, ei}, {48'h0, got_i[k]});
            check_eq("out_q_o", {48'h0, eq}, {48'h0, got_q[k]});
            if (n_found > 0) begin
               check_eq("out_time_o step", 64'(d), got_time[k] - prev);
            end
            exp_last = full_run && (n_found + 1 == count);
            check_eq("out_last_o", {63'h0, exp_last}, {63'h0, got_last[k]});
            prev = got_time[k];
            n_found++;
         end
      end
      if (full_run) begin
         check_eq("item count", 64'(count), 64'(n_found));
      end
   endtask

   //////////////////////////////////////////////////
   // Directed tests

   task automatic led_test();
      check_eq("leds_o", 64'h0, {56'h0, leds_o});
      write_reg(SR_LED_SW, 32'h0000_00A5);
      write_reg(SR_LED_SRC, 32'h0);
      check_eq("leds_o", 64'hA5, {56'h0, leds_o});
      write_reg(SR_LED_SRC, 32'h0000_0002);
      clear_items();
      start_chan(0, 8, 3);
      check_eq("leds_o", 64'hA7, {56'h0, leds_o});   // Bit 1 shows the run
      wait_items(3, T_LED);
      wait_idle(T_LED);
      check_eq("leds_o", 64'hA5, {56'h0, leds_o});
   endtask

   task automatic single_chan_test();
      sample_t fe_i;
      sample_t fe_q;
      int      d;
      int      n;
      d = 4 + int'($urandom % 5);
      random_front(fe_i, fe_q);
      clear_items();
      start_chan(0, d, 5);
      wait_items(5, T_SINGLE);
      wait_idle(T_SINGLE);
      check_chan(0, d, boxcar_value(d, fe_i), boxcar_value(d, fe_q), 5, 1'b1, n);
      check_eq("total items", 64'd5, 64'(got_i.size()));
      check_eq("overrun_o", 64'h0, {62'h0, overrun_o});
   endtask

   task automatic time_test();
      sample_t    fe_i;
      sample_t    fe_q;
      vita_time_t t0;
      int         n;
      t0 = {1'b0, 31'($urandom), $urandom};   // Top bit clear keeps the window from wrapping
      random_front(fe_i, fe_q);
      clear_items();
      write_reg(SR_TIME_HI, t0[63:32]);
      write_reg(SR_TIME_LO, t0[31:0]);
      start_chan(1, 6, 8);
      wait_items(8, T_TIME);
      wait_idle(T_TIME);
      check_chan(1, 6, boxcar_value(6, fe_i), boxcar_value(6, fe_q), 8, 1'b1, n);
      for (int k = 0; k < got_time.size(); k++) begin
         if (got_time[k] < t0 || got_time[k] >= t0 + 64'(T_TIME)) begin
            $display("FAILED t=%0t out_time_o expected in [%0h, %0h) got %0h",
                     $time, t0, t0 + 64'(T_TIME), got_time[k]);
            errors++;
         end
      end
   endtask

   task automatic dual_chan_test();
      sample_t fe_i;
      sample_t fe_q;
      int      n;
      random_front(fe_i, fe_q);
      clear_items();
      start_chan(0, 10, 6);
      start_chan(1, 14, 4);
      wait_items(10, T_DUAL);
      wait_idle(T_DUAL);
      check_chan(0, 10, boxcar_value(10, fe_i), boxcar_value(10, fe_q), 6, 1'b1, n);
      check_chan(1, 14, boxcar_value(14, fe_i), boxcar_value(14, fe_q), 4, 1'b1, n);
      check_eq("total items", 64'd10, 64'(got_i.size()));
   endtask

   task automatic overrun_test();
      sample_t fe_i;
      sample_t fe_q;
      int      n;
      random_front(fe_i, fe_q);
      clear_items();
      start_chan(0, 1, 50);
      wait_overrun(0, T_OVR);
      wait_idle(T_OVR);
      check_chan(0, 1, fe_i, fe_q, 50, 1'b0, n);
      if (n >= 50) begin
         $display("ERROR: channel 0 delivered all %0d items despite overrun", n);
         errors++;
      end
      clear_items();
      start_chan(0, 1, 1);
      check_eq("overrun_o[0]", 64'h0, {63'h0, overrun_o[0]});
      wait_items(1, T_OVR);
      wait_idle(T_OVR);
      check_chan(0, 1, fe_i, fe_q, 1, 1'b1, n);
   endtask

   task automatic backpressure_test();
      sample_t fe_i;
      sample_t fe_q;
      int      n;
      random_front(fe_i, fe_q);
      clear_items();
      @(negedge dsp_clk);
      hold_ack <= 1'b1;
      start_chan(0, 4, 40);
      repeat (40) @(negedge dsp_clk);
      check_eq("overrun_o[0]", 64'h1, {63'h0, overrun_o[0]});
      hold_ack <= 1'b0;
      wait_idle(T_BP);
      check_chan(0, 4, boxcar_value(4, fe_i), boxcar_value(4, fe_q), 40, 1'b0, n);
   endtask

   //////////////////////////////////////////////////
   // Main sequence

   initial begin
      errors     = 0;
      void'($urandom(32'h6ea0_5bbe));
      por_rst    <= 1'b1;
      set_stb_i  <= 1'b0;
      set_addr_i <= '0;
      set_data_i <= '0;
      adc_a_i    <= '0;
      adc_b_i    <= '0;
      hold_ack   <= 1'b0;
      repeat (RESET_CYCLES) @(negedge dsp_clk);
      por_rst <= 1'b0;
      @(negedge dsp_clk);

      led_test();
      single_chan_test();
      time_test();
      dual_chan_test();
      overrun_test();
      backpressure_test();

      $display("Run ended with %0d errors", errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule
